/* wisc_pkg.sv */
package wisc_pkg;

   // Machine word and register file index widths.
   localparam int DATA_W = 16;
   localparam int REG_W  = 3;

   typedef logic [DATA_W-1:0] word_t;
   typedef logic [REG_W-1:0]  reg_idx_t;

   // ALU operations as decoded by the ID stage.
   typedef enum logic [3:0] {
      ALU_ADD   = 4'd0,
      ALU_SUB   = 4'd1,
      ALU_XOR   = 4'd2,
      ALU_ANDN  = 4'd3,
      ALU_ROL   = 4'd4,
      ALU_SLL   = 4'd5,
      ALU_ROR   = 4'd6,
      ALU_SRL   = 4'd7,
      ALU_PASSB = 4'd8
   } alu_op_e;

   // Condition tested by SEQ, SLT, SLE and SCO.
   typedef enum logic [1:0] {
      SET_EQ = 2'd0,
      SET_LT = 2'd1,
      SET_LE = 2'd2,
      SET_CO = 2'd3
   } set_sel_e;

   // Source of the register file write data.
   typedef enum logic [2:0] {
      WB_ALU  = 3'd0,
      WB_MEM  = 3'd1,
      WB_PC   = 3'd2,
      WB_SET  = 3'd3,
      WB_LBI  = 3'd4,
      WB_SLBI = 3'd5
   } wr_sel_e;

endpackage

/* ex_mem_if.sv */
`timescale 1ns/1ps

interface ex_mem_if
   import wisc_pkg::*;
   ();

   // Data fields.
   word_t    pc_inc;
   word_t    rd_data_2;
   word_t    alu_out;
   word_t    lbi;
   word_t    slbi;
   logic     set_bit;

   // Control fields, cleared on a bubble.
   logic     mem_wr;
   logic     mem_en;
   logic     wr_en;
   logic     halt;

   reg_idx_t wr_reg;
   wr_sel_e  wr_sel;

   modport producer (
      output pc_inc, rd_data_2, alu_out, lbi, slbi, set_bit,
      output mem_wr, mem_en, wr_en, wr_reg, wr_sel, halt
   );

   modport consumer (
      input pc_inc, rd_data_2, alu_out, lbi, slbi, set_bit,
      input mem_wr, mem_en, wr_en, wr_reg, wr_sel, halt
   );

endinterface

/* mem_wb_if.sv */
`timescale 1ns/1ps

interface mem_wb_if
   import wisc_pkg::*;
   ();

   word_t    pc_inc;
   word_t    alu_out;
   word_t    mem_data;
   word_t    lbi;
   word_t    slbi;
   logic     set_bit;
   logic     wr_en;
   reg_idx_t wr_reg;
   wr_sel_e  wr_sel;
   logic     halt;

   modport producer (
      output pc_inc, alu_out, mem_data, lbi, slbi, set_bit,
      output wr_en, wr_reg, wr_sel, halt
   );

   modport consumer (
      input pc_inc, alu_out, mem_data, lbi, slbi, set_bit,
      input wr_en, wr_reg, wr_sel, halt
   );

endinterface

/* execute.sv */
`timescale 1ns/1ps

module execute
   import wisc_pkg::*;
   (
   input  word_t    pc_inc,
   input  word_t    rd_data_1,
   input  word_t    rd_data_2,
   input  word_t    sext_imm,
   input  logic     b_sel,
   input  alu_op_e  alu_op,
   input  set_sel_e set_sel,
   input  logic     mem_wr,
   input  logic     mem_en,
   input  logic     wr_en,
   input  logic     halt,
   input  reg_idx_t wr_reg,
   input  wr_sel_e  wr_sel,
   ex_mem_if.producer ex_bus
   );

   word_t                op_a;
   word_t                op_b;
   logic [3:0]           shamt;
   logic [2*DATA_W-1:0]  rol_full;
   logic [2*DATA_W-1:0]  ror_full;
   word_t                alu_res;
   word_t                diff;
   logic [DATA_W:0]      sum_c;
   logic                 sub_ofl;
   logic                 zero;
   logic                 ltz;
   logic                 lteq;
   logic                 carry;
   logic                 set_res;

   assign op_a  = rd_data_1;
   assign op_b  = b_sel ? sext_imm : rd_data_2;
   assign shamt = op_b[3:0];

   // Rotates take the upper or lower half of the doubled operand.
   assign rol_full = {op_a, op_a} << shamt;
   assign ror_full = {op_a, op_a} >> shamt;

   always_comb begin
      case (alu_op)
         ALU_ADD:   alu_res = op_a + op_b;
         ALU_SUB:   alu_res = op_a - op_b;
         ALU_XOR:   alu_res = op_a ^ op_b;
         ALU_ANDN:  alu_res = op_a & ~op_b;
         ALU_ROL:   alu_res = rol_full[2*DATA_W-1:DATA_W];
         ALU_SLL:   alu_res = op_a << shamt;
         ALU_ROR:   alu_res = ror_full[DATA_W-1:0];
         ALU_SRL:   alu_res = op_a >> shamt;
         ALU_PASSB: alu_res = op_b;
         default:   alu_res = '0;
      endcase
   end

   // Flags come from a dedicated comparison that is independent of alu_op.
   assign diff    = op_a - op_b;
   assign sub_ofl = (op_a[DATA_W-1] != op_b[DATA_W-1]) &&
                    (diff[DATA_W-1] != op_a[DATA_W-1]);
   assign zero    = (diff == '0);
   assign ltz     = diff[DATA_W-1] ^ sub_ofl;
   assign lteq    = ltz | zero;
   assign sum_c   = {1'b0, op_a} + {1'b0, op_b};
   assign carry   = sum_c[DATA_W];

   always_comb begin
      case (set_sel)
         SET_EQ:  set_res = zero;
         SET_LT:  set_res = ltz;
         SET_LE:  set_res = lteq;
         SET_CO:  set_res = carry;
         default: set_res = 1'b0;
      endcase
   end

   assign ex_bus.pc_inc    = pc_inc;
   assign ex_bus.rd_data_2 = rd_data_2;
   assign ex_bus.alu_out   = alu_res;
   assign ex_bus.set_bit   = set_res;
   assign ex_bus.lbi       = sext_imm;
   // Upper byte comes from the old register value and lower byte from the immediate.
   assign ex_bus.slbi      = {rd_data_1[DATA_W-9:0], sext_imm[7:0]};

   assign ex_bus.mem_wr = mem_wr;
   assign ex_bus.mem_en = mem_en;
   assign ex_bus.wr_en  = wr_en;
   assign ex_bus.halt   = halt;
   assign ex_bus.wr_reg = wr_reg;
   assign ex_bus.wr_sel = wr_sel;

endmodule

/* ex_mem.sv */
`timescale 1ns/1ps

module ex_mem
   import wisc_pkg::*;
   (
   input  logic       clk,
   input  logic       reset,
   input  logic       stall_n,
   ex_mem_if.consumer ex_bus,
   ex_mem_if.producer mem_bus
   );

   always_ff @(posedge clk) begin
      if (reset) begin
         mem_bus.pc_inc    <= '0;
         mem_bus.rd_data_2 <= '0;
         mem_bus.alu_out   <= '0;
         mem_bus.lbi       <= '0;
         mem_bus.slbi      <= '0;
         mem_bus.set_bit   <= 1'b0;
         mem_bus.wr_reg    <= '0;
         mem_bus.wr_sel    <= WB_ALU;
         mem_bus.mem_wr    <= 1'b0;
         mem_bus.mem_en    <= 1'b0;
         mem_bus.wr_en     <= 1'b0;
         mem_bus.halt      <= 1'b0;
      end else if (stall_n) begin
         mem_bus.pc_inc    <= ex_bus.pc_inc;
         mem_bus.rd_data_2 <= ex_bus.rd_data_2;
         mem_bus.alu_out   <= ex_bus.alu_out;
         mem_bus.lbi       <= ex_bus.lbi;
         mem_bus.slbi      <= ex_bus.slbi;
         mem_bus.set_bit   <= ex_bus.set_bit;
         mem_bus.wr_reg    <= ex_bus.wr_reg;
         mem_bus.wr_sel    <= ex_bus.wr_sel;
         mem_bus.mem_wr    <= ex_bus.mem_wr;
         mem_bus.mem_en    <= ex_bus.mem_en;
         mem_bus.wr_en     <= ex_bus.wr_en;
         mem_bus.halt      <= ex_bus.halt;
      end else begin
         // Bubble that holds the data fields and has no side effects downstream.
         mem_bus.mem_wr <= 1'b0;
         mem_bus.mem_en <= 1'b0;
         mem_bus.wr_en  <= 1'b0;
         mem_bus.halt   <= 1'b0;
      end
   end

endmodule

/* mem_stage.sv */
`timescale 1ns/1ps

module mem_stage
   import wisc_pkg::*;
   #(
   parameter int DMEM_WORDS = 256
   )
   (
   input  logic       clk,
   ex_mem_if.consumer mem_bus,
   mem_wb_if.producer wb_bus
   );

   localparam int ADDR_W = $clog2(DMEM_WORDS);

   word_t             dmem [DMEM_WORDS];
   logic [ADDR_W-1:0] addr;
   logic              store;

   // Word address that wraps at the memory depth.
   assign addr  = mem_bus.alu_out[ADDR_W-1:0];
   assign store = mem_bus.mem_en & mem_bus.mem_wr;

   always_ff @(posedge clk) begin
      if (store) begin
         dmem[addr] <= mem_bus.rd_data_2;
      end
   end

   // Read is combinational, so a load right after a store sees the new word.
   assign wb_bus.mem_data = dmem[addr];

   assign wb_bus.pc_inc  = mem_bus.pc_inc;
   assign wb_bus.alu_out = mem_bus.alu_out;
   assign wb_bus.lbi     = mem_bus.lbi;
   assign wb_bus.slbi    = mem_bus.slbi;
   assign wb_bus.set_bit = mem_bus.set_bit;
   assign wb_bus.wr_en   = mem_bus.wr_en;
   assign wb_bus.wr_reg  = mem_bus.wr_reg;
   assign wb_bus.wr_sel  = mem_bus.wr_sel;
   assign wb_bus.halt    = mem_bus.halt;

endmodule

/* wb_stage.sv */
`timescale 1ns/1ps

module wb_stage
   import wisc_pkg::*;
   (
   input  logic       clk,
   input  logic       reset,
   mem_wb_if.consumer wb_bus,
   output logic       wb_en,
   output reg_idx_t   wb_reg,
   output word_t      wb_data,
   output logic       halt_out
   );

   word_t   pc_inc_q;
   word_t   alu_out_q;
   word_t   mem_data_q;
   word_t   lbi_q;
   word_t   slbi_q;
   logic    set_bit_q;
   wr_sel_e wr_sel_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         pc_inc_q   <= '0;
         alu_out_q  <= '0;
         mem_data_q <= '0;
         lbi_q      <= '0;
         slbi_q     <= '0;
         set_bit_q  <= 1'b0;
         wr_sel_q   <= WB_ALU;
         wb_en      <= 1'b0;
         wb_reg     <= '0;
         halt_out   <= 1'b0;
      end else begin
         pc_inc_q   <= wb_bus.pc_inc;
         alu_out_q  <= wb_bus.alu_out;
         mem_data_q <= wb_bus.mem_data;
         lbi_q      <= wb_bus.lbi;
         slbi_q     <= wb_bus.slbi;
         set_bit_q  <= wb_bus.set_bit;
         wr_sel_q   <= wb_bus.wr_sel;
         wb_en      <= wb_bus.wr_en;
         wb_reg     <= wb_bus.wr_reg;
         halt_out   <= wb_bus.halt;
      end
   end

   // Register file write data.
   always_comb begin
      case (wr_sel_q)
         WB_ALU:  wb_data = alu_out_q;
         WB_MEM:  wb_data = mem_data_q;
         WB_PC:   wb_data = pc_inc_q;
         WB_SET:  wb_data = {{(DATA_W-1){1'b0}}, set_bit_q};
         WB_LBI:  wb_data = lbi_q;
         WB_SLBI: wb_data = slbi_q;
         default: wb_data = alu_out_q;
      endcase
   end

endmodule

/* exwb_pipe.sv */
`timescale 1ns/1ps

module exwb_pipe
   import wisc_pkg::*;
   #(
   parameter int DMEM_WORDS = 256
   )
   (
   input  logic     clk,
   input  logic     reset,
   input  logic     stall_n,
   input  word_t    pc_inc,
   input  word_t    rd_data_1,
   input  word_t    rd_data_2,
   input  word_t    sext_imm,
   input  logic     b_sel,
   input  alu_op_e  alu_op,
   input  set_sel_e set_sel,
   input  logic     mem_wr,
   input  logic     mem_en,
   input  logic     wr_en,
   input  logic     halt,
   input  reg_idx_t wr_reg,
   input  wr_sel_e  wr_sel,
   output logic     wb_en,
   output reg_idx_t wb_reg,
   output word_t    wb_data,
   output logic     halt_out
   );

   ex_mem_if ex_bus ();
   ex_mem_if mem_bus ();
   mem_wb_if wb_bus ();

   execute i_execute (
      .pc_inc    (pc_inc),
      .rd_data_1 (rd_data_1),
      .rd_data_2 (rd_data_2),
      .sext_imm  (sext_imm),
      .b_sel     (b_sel),
      .alu_op    (alu_op),
      .set_sel   (set_sel),
      .mem_wr    (mem_wr),
      .mem_en    (mem_en),
      .wr_en     (wr_en),
      .halt      (halt),
      .wr_reg    (wr_reg),
      .wr_sel    (wr_sel),
      .ex_bus    (ex_bus.producer)
   );

   ex_mem i_ex_mem (
      .clk     (clk),
      .reset   (reset),
      .stall_n (stall_n),
      .ex_bus  (ex_bus.consumer),
      .mem_bus (mem_bus.producer)
   );

   mem_stage #(
      .DMEM_WORDS (DMEM_WORDS)
   ) i_mem_stage (
      .clk     (clk),
      .mem_bus (mem_bus.consumer),
      .wb_bus  (wb_bus.producer)
   );

   wb_stage i_wb_stage (
      .clk      (clk),
      .reset    (reset),
      .wb_bus   (wb_bus.consumer),
      .wb_en    (wb_en),
      .wb_reg   (wb_reg),
      .wb_data  (wb_data),
      .halt_out (halt_out)
   );

endmodule

/* tb_exwb_pipe.sv */
`timescale 1ns/1ps

module tb_exwb_pipe
   import wisc_pkg::*;
   ();

   localparam int DMEM_WORDS  = 256;
   localparam int TEST_CYCLES = 90;
   localparam int CYCLE_LIMIT = 2 * TEST_CYCLES + 100;

   // Set test operand pairs cover equal, signed negative, carry out and plain less-than.
   localparam word_t SET_A [4] = '{16'h1234, 16'h8000, 16'hffff, 16'h0003};
   localparam word_t SET_B [4] = '{16'h1234, 16'h0001, 16'h0001, 16'h7fff};

   logic     clk;
   logic     reset;
   logic     stall_n;
   word_t    pc_inc;
   word_t    rd_data_1;
   word_t    rd_data_2;
   word_t    sext_imm;
   logic     b_sel;
   alu_op_e  alu_op;
   set_sel_e set_sel;
   logic     mem_wr;
   logic     mem_en;
   logic     wr_en;
   logic     halt;
   reg_idx_t wr_reg;
   wr_sel_e  wr_sel;
   logic     wb_en;
   reg_idx_t wb_reg;
   word_t    wb_data;
   logic     halt_out;

   int       err_cnt;
   int       check_cnt;
   int       cycle_cnt;

   // Expected write-back. Index 1 is due at the next edge.
   logic     pend_en [2];
   logic     pend_halt [2];
   reg_idx_t pend_reg [2];
   word_t    pend_data [2];
   word_t    shadow [DMEM_WORDS];

   exwb_pipe #(
      .DMEM_WORDS (DMEM_WORDS)
   ) i_dut (
      .clk       (clk),
      .reset     (reset),
      .stall_n   (stall_n),
      .pc_inc    (pc_inc),
      .rd_data_1 (rd_data_1),
      .rd_data_2 (rd_data_2),
      .sext_imm  (sext_imm),
      .b_sel     (b_sel),
      .alu_op    (alu_op),
      .set_sel   (set_sel),
      .mem_wr    (mem_wr),
      .mem_en    (mem_en),
      .wr_en     (wr_en),
      .halt      (halt),
      .wr_reg    (wr_reg),
      .wr_sel    (wr_sel),
      .wb_en     (wb_en),
      .wb_reg    (wb_reg),
      .wb_data   (wb_data),
      .halt_out  (halt_out)
   );

   always #50 clk = ~clk;

   function automatic word_t rand_word();
      logic [31:0] r;
      r = $urandom();
      return r[15:0];
   endfunction

   function automatic reg_idx_t rand_reg();
      logic [31:0] r;
      r = $urandom();
      return r[2:0];
   endfunction

   function automatic word_t alu_model(input alu_op_e op, input word_t a, input word_t b);
      word_t r;
      int    sh;
      sh = int'(b[3:0]);
      r  = a;
      case (op)
         ALU_ADD:   r = a + b;
         ALU_SUB:   r = a - b;
         ALU_XOR:   r = a ^ b;
         ALU_ANDN:  r = a & ~b;
         ALU_ROL:   for (int i = 0; i < sh; i++) r = {r[14:0], r[15]};
         ALU_ROR:   for (int i = 0; i < sh; i++) r = {r[0], r[15:1]};
         ALU_SLL:   r = a << b[3:0];
         ALU_SRL:   r = a >> b[3:0];
         default:   r = b;
      endcase
      return r;
   endfunction

   function automatic logic set_model(input set_sel_e sel, input word_t a, input word_t b);
      case (sel)
         SET_EQ:  return a == b;
         SET_LT:  return $signed(a) < $signed(b);
         SET_LE:  return $signed(a) <= $signed(b);
         default: return (int'(a) + int'(b)) > 32'h0000_ffff;
      endcase
   endfunction

   task automatic check_word(input string name, input word_t exp, input word_t act);
      check_cnt++;
      if (act !== exp) begin
         err_cnt++;
         $display("error: %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_reg(input string name, input reg_idx_t exp, input reg_idx_t act);
      check_cnt++;
      if (act !== exp) begin
         err_cnt++;
         $display("error: %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      check_cnt++;
      if (act !== exp) begin
         err_cnt++;
         $display("error: %s expected %h actual %h", name, exp, act);
      end
   endtask

   // Steps one edge, checks what is due and shifts the expectation pipe.
   task automatic advance_cycle();
      @(posedge clk);
      #1;
      check_bit("wb_en", pend_en[1], wb_en);
      check_bit("halt_out", pend_halt[1], halt_out);
      if (pend_en[1]) begin
         check_reg("wb_reg", pend_reg[1], wb_reg);
         check_word("wb_data", pend_data[1], wb_data);
      end
      pend_en[1]   = pend_en[0];
      pend_halt[1] = pend_halt[0];
      pend_reg[1]  = pend_reg[0];
      pend_data[1] = pend_data[0];
      pend_en[0]   = 1'b0;
      pend_halt[0] = 1'b0;
   endtask

   task automatic issue_instr(input word_t pc, input word_t a, input word_t b,
                              input word_t imm, input logic bs, input alu_op_e op,
                              input set_sel_e ss, input logic mw, input logic me,
                              input logic we, input logic hl, input reg_idx_t r,
                              input wr_sel_e ws, input logic go);
      word_t b_eff;
      word_t alu;
      word_t res;
      int    idx;
      b_eff = bs ? imm : b;
      alu   = alu_model(op, a, b_eff);
      idx   = int'(alu) % DMEM_WORDS;
      case (ws)
         WB_MEM:  res = shadow[idx];
         WB_PC:   res = pc;
         WB_SET:  res = {{(DATA_W-1){1'b0}}, set_model(ss, a, b_eff)};
         WB_LBI:  res = imm;
         WB_SLBI: res = (a << 8) | (imm & 16'h00ff);
         default: res = alu;
      endcase
      pc_inc    = pc;
      rd_data_1 = a;
      rd_data_2 = b;
      sext_imm  = imm;
      b_sel     = bs;
      alu_op    = op;
      set_sel   = ss;
      mem_wr    = mw;
      mem_en    = me;
      wr_en     = we;
      halt      = hl;
      wr_reg    = r;
      wr_sel    = ws;
      stall_n   = go;
      // A stalled issue never reaches write-back or memory.
      if (go) begin
         pend_en[0]   = we;
         pend_halt[0] = hl;
         pend_reg[0]  = r;
         pend_data[0] = res;
         if (me && mw) begin
            shadow[idx] = b;
         end
      end
      advance_cycle();
   endtask

   task automatic issue_alu(input alu_op_e op, input word_t a, input word_t b,
                            input word_t imm, input logic bs, input reg_idx_t r);
      issue_instr(16'h0, a, b, imm, bs, op, SET_EQ, 1'b0, 1'b0, 1'b1, 1'b0, r, WB_ALU, 1'b1);
   endtask

   task automatic issue_store(input word_t base, input word_t off, input word_t data,
                              input logic go);
      issue_instr(16'h0, base, data, off, 1'b1, ALU_ADD, SET_EQ, 1'b1, 1'b1, 1'b0, 1'b0,
                  3'd0, WB_ALU, go);
   endtask

   task automatic issue_load(input word_t base, input word_t off, input reg_idx_t r);
      issue_instr(16'h0, base, rand_word(), off, 1'b1, ALU_ADD, SET_EQ, 1'b0, 1'b1, 1'b1,
                  1'b0, r, WB_MEM, 1'b1);
   endtask

   task automatic flush_pipe();
      repeat (2) begin
         issue_instr(16'h0, 16'h0, 16'h0, 16'h0, 1'b0, ALU_ADD, SET_EQ, 1'b0, 1'b0, 1'b0,
                     1'b0, 3'd0, WB_ALU, 1'b1);
      end
   endtask

   task automatic reset_outputs_low();
      check_bit("wb_en", 1'b0, wb_en);
      check_bit("halt_out", 1'b0, halt_out);
      issue_alu(ALU_ADD, rand_word(), rand_word(), 16'h0, 1'b0, 3'd1);
      flush_pipe();
   endtask

   task automatic alu_ops_back_to_back();
      for (int round = 0; round < 2; round++) begin
         for (int i = 0; i < 9; i++) begin
            for (int s = 0; s < 2; s++) begin
               issue_alu(alu_op_e'(i), rand_word(), rand_word(), rand_word(), s == 1,
                         rand_reg());
            end
         end
      end
      flush_pipe();
   endtask

   task automatic set_conditions();
      for (int k = 0; k < 4; k++) begin
         for (int c = 0; c < 4; c++) begin
            issue_instr(16'h0, SET_A[c], SET_B[c], 16'h0, 1'b0, ALU_SUB, set_sel_e'(k),
                        1'b0, 1'b0, 1'b1, 1'b0, rand_reg(), WB_SET, 1'b1);
         end
      end
      flush_pipe();
   endtask

   task automatic immediate_and_pc_select();
      issue_instr(rand_word(), rand_word(), rand_word(), rand_word(), 1'b1, ALU_PASSB,
                  SET_EQ, 1'b0, 1'b0, 1'b1, 1'b0, rand_reg(), WB_LBI, 1'b1);
      issue_instr(rand_word(), rand_word(), rand_word(), rand_word(), 1'b1, ALU_PASSB,
                  SET_EQ, 1'b0, 1'b0, 1'b1, 1'b0, rand_reg(), WB_SLBI, 1'b1);
      issue_instr(rand_word(), rand_word(), rand_word(), rand_word(), 1'b0, ALU_ADD,
                  SET_EQ, 1'b0, 1'b0, 1'b1, 1'b0, rand_reg(), WB_PC, 1'b1);
      flush_pipe();
   endtask

   task automatic store_then_load();
      issue_store(16'd10, 16'd3, rand_word(), 1'b1);
      issue_load(16'd10, 16'd3, 3'd2);
      // Address 0x105 wraps onto word 5.
      issue_store(16'h0100, 16'h0005, rand_word(), 1'b1);
      issue_load(16'd0, 16'd13, 3'd3);
      issue_load(16'd5, 16'd0, 3'd4);
      flush_pipe();
   endtask

   task automatic stall_bubble_and_halt();
      issue_store(16'd40, 16'd0, rand_word(), 1'b1);
      issue_store(16'd40, 16'd0, rand_word(), 1'b0);
      issue_alu(ALU_XOR, rand_word(), rand_word(), 16'h0, 1'b0, 3'd6);
      issue_instr(16'h0, rand_word(), rand_word(), 16'h0, 1'b0, ALU_ADD, SET_EQ, 1'b0,
                  1'b0, 1'b1, 1'b0, 3'd7, WB_ALU, 1'b0);
      issue_instr(16'h0, 16'h0, 16'h0, 16'h0, 1'b0, ALU_ADD, SET_EQ, 1'b0, 1'b0, 1'b0,
                  1'b1, 3'd0, WB_ALU, 1'b1);
      issue_load(16'd40, 16'd0, 3'd5);
      flush_pipe();
   endtask

   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < CYCLE_LIMIT) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Checks failed");
      $finish;
   end

   initial begin
      void'($urandom(32'h29a3f4cc));
      err_cnt    = 0;
      check_cnt  = 0;
      clk        = 1'b0;
      reset      = 1'b1;
      stall_n    = 1'b1;
      pc_inc     = '0;
      rd_data_1  = '0;
      rd_data_2  = '0;
      sext_imm   = '0;
      b_sel      = 1'b0;
      alu_op     = ALU_ADD;
      set_sel    = SET_EQ;
      mem_wr     = 1'b0;
      mem_en     = 1'b0;
      wr_en      = 1'b0;
      halt       = 1'b0;
      wr_reg     = '0;
      wr_sel     = WB_ALU;
      for (int i = 0; i < 2; i++) begin
         pend_en[i]   = 1'b0;
         pend_halt[i] = 1'b0;
         pend_reg[i]  = '0;
         pend_data[i] = '0;
      end
      repeat (8) @(posedge clk);
      #1;
      reset = 1'b0;

      reset_outputs_low();
      alu_ops_back_to_back();
      set_conditions();
      immediate_and_pc_select();
      store_then_load();
      stall_bubble_and_halt();

      $display("Summary: %0d checks, %0d errors", check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

/* flist.f */
wisc_pkg.sv
ex_mem_if.sv
mem_wb_if.sv
execute.sv
ex_mem.sv
mem_stage.sv
wb_stage.sv
exwb_pipe.sv
tb_exwb_pipe.sv

/* run.sh */
#!/bin/sh
# Build and run the EX/MEM/WB testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/1ps --top-module tb_exwb_pipe \
   -f flist.f -o sim_exwb_pipe
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

output=$(./obj_dir/sim_exwb_pipe)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "All checks passed"; then
   exit 0
fi
echo "Pass message not found in simulation output"
exit 1
